// ==== audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	// packed stereo sample, left channel in the upper half.
	typedef logic [31:0] sample_t;

	// bus register map.
	localparam logic [3:0] ADDR_DATA    = 4'h0; // write pushes a sample, read gives fill count.
	localparam logic [3:0] ADDR_DIVISOR = 4'h1; // bit-clock half-period in system clocks.
	localparam logic [3:0] ADDR_STATUS  = 4'h2; // bit 0 is the sticky underrun flag.

	// divisor after reset.
	localparam logic [31:0] DIVISOR_RESET = 32'd4;

	// channel helpers for the packed sample.
	function automatic logic [15:0] left_of(sample_t s);
		return s[31:16];
	endfunction

	function automatic logic [15:0] right_of(sample_t s);
		return s[15:0];
	endfunction

endpackage

`default_nettype wire

// ==== sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
	parameter int DEPTH = 16
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_push,
	input wire audio_pkg::sample_t i_wdata,
	input wire i_pop,
	output audio_pkg::sample_t o_head,
	output logic o_empty,
	output logic o_full,
	output logic [$clog2(DEPTH):0] o_count
);
	import audio_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	sample_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic push_ok;
	logic pop_ok;

	// requests against a full or empty queue are dropped.
	assign push_ok = i_push && !o_full;
	assign pop_ok = i_pop && !o_empty;

	assign o_empty = (o_count == '0);
	assign o_full = (o_count == FULL_COUNT);
	assign o_head = mem[rd_ptr]; // first word falls through.

	// storage, no reset needed.
	always_ff @(posedge i_clock) begin
		if (push_ok)
			mem[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push_ok, pop_ok})
				2'b10: o_count <= o_count + 1'b1;
				2'b01: o_count <= o_count - 1'b1;
				default: o_count <= o_count; // both or neither.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== audio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_regs #(
	parameter int DEPTH = 16
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_request,
	input wire i_rw,
	input wire [3:0] i_address,
	input wire [31:0] i_wdata,
	input wire i_fifo_full,
	input wire [$clog2(DEPTH):0] i_fifo_count,
	input wire i_underrun,
	output logic [31:0] o_rdata,
	output logic o_ready,
	output logic o_push,
	output audio_pkg::sample_t o_push_data,
	output logic [31:0] o_divisor,
	output logic o_interrupt
);
	import audio_pkg::*;

	localparam int CW = $clog2(DEPTH) + 1;
	localparam logic [CW-1:0] HALF = CW'(DEPTH / 2);

	typedef enum logic {
		S_IDLE,
		S_ACK
	} state_t;

	state_t state;
	logic underrun_flag;
	logic accept;
	logic data_write;
	logic status_read;
	logic [1:0] above_half;

	// data writes stall while the fifo is full.
	assign data_write = i_rw && (i_address == ADDR_DATA);
	assign accept = (state == S_IDLE) && i_request && !(data_write && i_fifo_full);
	assign status_read = accept && !i_rw && (i_address == ADDR_STATUS);

	assign o_ready = (state == S_ACK);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			o_push <= 1'b0;
			o_divisor <= DIVISOR_RESET;
		end else begin
			o_push <= accept && data_write;
			case (state)
				S_IDLE: if (accept) state <= S_ACK;
				S_ACK: if (!i_request) state <= S_IDLE; // cpu has seen ready.
				default: state <= S_IDLE;
			endcase
			if (accept && i_rw && (i_address == ADDR_DIVISOR))
				o_divisor <= i_wdata;
		end
	end

	// read data and pushed sample, captured at accept.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_push_data <= i_wdata;
			if (i_rw) begin
				o_rdata <= '0;
			end else begin
				case (i_address)
					ADDR_DATA: o_rdata <= 32'(i_fifo_count);
					ADDR_DIVISOR: o_rdata <= o_divisor;
					ADDR_STATUS: o_rdata <= {31'd0, underrun_flag};
					default: o_rdata <= '0;
				endcase
			end
		end
	end

	// sticky, a new underrun wins over the clearing read.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			underrun_flag <= 1'b0;
		else if (i_underrun)
			underrun_flag <= 1'b1;
		else if (status_read)
			underrun_flag <= 1'b0;
	end

	// older sample in bit 1.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			above_half <= 2'b00;
		else
			above_half <= {above_half[0], i_fifo_count > HALF};
	end

	assign o_interrupt = (above_half == 2'b10); // dropped to half or below.

endmodule

`default_nettype wire

// ==== rate_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module rate_timer (
	input wire i_clock,
	input wire i_rst_n,
	input wire [31:0] i_divisor,
	output logic o_tick
);
	logic [31:0] count;
	logic [31:0] reload;
	logic expired;

	// zero divisor behaves like one.
	assign reload = (i_divisor == 32'd0) ? 32'd1 : i_divisor;

	// last cycle of the period.
	assign expired = (count <= 32'd1);

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			count <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= expired;
			if (expired)
				count <= reload; // new divisor is picked up here.
			else
				count <= count - 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== sample_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_serializer (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_tick,
	input wire i_empty,
	input wire audio_pkg::sample_t i_head,
	output logic o_pop,
	output logic o_underrun,
	output logic o_bclk,
	output logic o_ws,
	output logic o_sdata
);
	import audio_pkg::*;

	sample_t shift_q;
	sample_t frame_word;
	logic [4:0] bit_cnt;
	logic fall_tick;
	logic frame_start;

	// a tick while bclk is high drives it low.
	assign fall_tick = i_tick && o_bclk;
	assign frame_start = fall_tick && (bit_cnt == 5'd0);

	// empty fifo at frame start means a silent frame.
	assign frame_word = i_empty ? sample_t'(0) : {left_of(i_head), right_of(i_head)};

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_bclk <= 1'b0;
			o_ws <= 1'b0;
			o_sdata <= 1'b0;
			o_pop <= 1'b0;
			o_underrun <= 1'b0;
			bit_cnt <= '0;
		end else begin
			o_pop <= frame_start && !i_empty;
			o_underrun <= frame_start && i_empty;

			if (i_tick)
				o_bclk <= !o_bclk;

			if (fall_tick) begin
				o_ws <= bit_cnt[4]; // right half from bit 16 on.
				bit_cnt <= bit_cnt + 5'd1; // wraps into the next frame.
				if (bit_cnt == 5'd0)
					o_sdata <= frame_word[31];
				else
					o_sdata <= shift_q[31];
			end
		end
	end

	// msb leaves first, the rest waits here.
	always_ff @(posedge i_clock) begin
		if (frame_start)
			shift_q <= {frame_word[30:0], 1'b0};
		else if (fall_tick)
			shift_q <= {shift_q[30:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== audio_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_top #(
	parameter int DEPTH = 16
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_request,
	input wire i_rw,
	input wire [3:0] i_address,
	input wire [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,
	output logic o_bclk,
	output logic o_ws,
	output logic o_sdata
);
	import audio_pkg::*;

	sample_t push_data;
	sample_t head;
	logic push;
	logic pop;
	logic empty;
	logic full;
	logic underrun;
	logic tick;
	logic [31:0] divisor;
	logic [$clog2(DEPTH):0] count;

	sample_fifo #(
		.DEPTH(DEPTH)
	) fifo_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_push(push),
		.i_wdata(push_data),
		.i_pop(pop),
		.o_head(head),
		.o_empty(empty),
		.o_full(full),
		.o_count(count)
	);

	audio_regs #(
		.DEPTH(DEPTH)
	) regs_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_fifo_full(full),
		.i_fifo_count(count),
		.i_underrun(underrun),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_push(push),
		.o_push_data(push_data),
		.o_divisor(divisor),
		.o_interrupt(o_interrupt)
	);

	rate_timer timer_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_divisor(divisor),
		.o_tick(tick)
	);

	sample_serializer ser_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_tick(tick),
		.i_empty(empty),
		.i_head(head),
		.o_pop(pop),
		.o_underrun(underrun),
		.o_bclk(o_bclk),
		.o_ws(o_ws),
		.o_sdata(o_sdata)
	);

endmodule

`default_nettype wire

// ==== audio_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_properties (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_request,
	input wire i_ready,
	input wire i_interrupt,
	input wire i_push
);

	// ready only answers a pending request.
	ready_needs_request: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_ready) |-> $past(i_request)
	) else $error("o_ready rose without a request");

	interrupt_one_cycle: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		i_interrupt |=> !i_interrupt
	) else $error("o_interrupt stayed high for more than one cycle");

	// the push pulse shares its cycle with the ready rise.
	push_with_ready: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		i_push |-> $rose(i_ready)
	) else $error("o_push without a rising o_ready");

endmodule

`default_nettype wire

// ==== tb_audio.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_audio;
	import audio_pkg::*;

	localparam int DEPTH = 16;
	localparam time PERIOD = 40;
	localparam time LOAD_LAG = 2 * PERIOD; // push edge to first frame start that sees it.
	localparam int BUS_TIMEOUT = 200;

	logic clock;
	logic rst_n;
	logic request;
	logic rw;
	logic [3:0] address;
	logic [31:0] wdata;
	wire [31:0] rdata;
	wire ready;
	wire interrupt;
	wire bclk;
	wire ws;
	wire sdata;

	integer seed = 32'hb637;
	int errors = 0;
	int checks = 0;
	int irq_count = 0;
	int silent_frames = 0;
	int next_idx = 0; // next written sample still owed by the serial port.
	sample_t sent_q[$];
	time sent_t_q[$];
	sample_t rx_q[$];
	time rx_t_q[$];

	audio_top #(
		.DEPTH(DEPTH)
	) dut_i (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_interrupt(interrupt),
		.o_bclk(bclk),
		.o_ws(ws),
		.o_sdata(sdata)
	);

	bind audio_regs audio_properties props_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_ready(o_ready),
		.i_interrupt(o_interrupt),
		.i_push(o_push)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("ERROR: timed out waiting for %s", what);
		finish_run();
	endtask

	// four-phase request/ready cycle, inputs move 2 ns after the edge.
	task automatic bus_transfer(input logic write, input logic [3:0] addr,
			input logic [31:0] data, output logic [31:0] result);
		int n;
		@(posedge clock);
		#2;
		request = 1'b1;
		rw = write;
		address = addr;
		wdata = data;
		n = 0;
		while (!ready) begin
			@(posedge clock);
			#2;
			n++;
			if (n > BUS_TIMEOUT)
				timed_out("o_ready to rise");
		end
		result = rdata;
		if (write && addr == ADDR_DATA) begin
			sent_q.push_back(data);
			sent_t_q.push_back($time - 2); // edge of the push pulse.
		end
		request = 1'b0;
		n = 0;
		while (ready) begin
			@(posedge clock);
			#2;
			n++;
			if (n > BUS_TIMEOUT)
				timed_out("o_ready to fall");
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_transfer(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
		bus_transfer(1'b0, addr, 32'd0, data);
	endtask

	task automatic wait_bclk_rise(output time t);
		int n;
		logic last;
		n = 0;
		last = 1'b1;
		while (!(bclk && !last)) begin
			last = bclk;
			@(posedge clock);
			#2;
			n++;
			if (n > BUS_TIMEOUT)
				timed_out("a rising bit clock");
		end
		t = $time - 2;
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (next_idx < sent_q.size()) begin
			@(posedge clock);
			n++;
			if (n > limit)
				timed_out("the FIFO to drain");
		end
	endtask

	task automatic wait_silent(input int target, input int limit);
		int n;
		n = 0;
		while (silent_frames < target) begin
			@(posedge clock);
			n++;
			if (n > limit)
				timed_out("silent frames");
		end
	endtask

	// word owed by a frame loaded at edge t.
	function automatic sample_t expect_frame(input time t);
		if (next_idx < sent_q.size() && sent_t_q[next_idx] + LOAD_LAG <= t) begin
			next_idx++;
			return sent_q[next_idx - 1];
		end
		return '0; // fifo had run empty, silence.
	endfunction

	// serial receiver, bits taken on bclk rises.
	initial begin : receiver
		logic prev_bclk;
		logic prev_ws;
		logic [31:0] word;
		int nbits;
		time fall_t;
		time start_t;
		prev_bclk = 1'b0;
		prev_ws = 1'b0;
		word = '0;
		nbits = -1; // not aligned yet.
		fall_t = 0;
		start_t = 0;
		forever begin
			@(posedge clock);
			#2;
			if (prev_bclk && !bclk)
				fall_t = $time - 2;
			if (!prev_bclk && bclk) begin
				if (prev_ws && !ws) begin
					nbits = 0; // left word starts.
					start_t = fall_t;
				end
				if (nbits >= 0) begin
					check("word select", 32'(nbits >= 16), 32'(ws));
					word = {word[30:0], sdata};
					nbits++;
					if (nbits == 32) begin
						rx_q.push_back(word);
						rx_t_q.push_back(start_t);
						nbits = -1;
					end
				end
				prev_ws = ws;
			end
			prev_bclk = bclk;
		end
	end

	initial begin : compare
		sample_t got;
		sample_t want;
		time t;
		forever begin
			@(posedge clock);
			while (rx_q.size() > 0) begin
				got = rx_q.pop_front();
				t = rx_t_q.pop_front();
				want = expect_frame(t);
				if (want == '0)
					silent_frames++;
				check("serial frame", want, got);
			end
		end
	end

	initial begin : irq_monitor
		forever begin
			@(posedge clock);
			#2;
			if (interrupt)
				irq_count++;
		end
	end

	initial begin : stimulus
		logic [31:0] value;
		time t_a;
		time t_b;
		int base;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		rst_n = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		rst_n = 1'b1;

		bus_read(ADDR_DIVISOR, value);
		check("reset divisor", DIVISOR_RESET, value);
		bus_read(ADDR_DATA, value);
		check("reset count", 32'd0, value);

		bus_write(ADDR_DIVISOR, 32'd3);
		bus_read(ADDR_DIVISOR, value);
		check("divisor readback", 32'd3, value);
		wait_bclk_rise(t_a); // may still use the old period.
		wait_bclk_rise(t_a);
		wait_bclk_rise(t_b);
		check("bit clock period", 32'd6, 32'((t_b - t_a) / PERIOD));

		// a frame every 128 clocks keeps stalled writes inside the timeout.
		bus_write(ADDR_DIVISOR, 32'd2);
		for (int i = 0; i < 40; i++)
			bus_write(ADDR_DATA, $random(seed));
		wait_drained(20000);

		bus_write(ADDR_DIVISOR, 32'd3);
		for (int i = 0; i < DEPTH + 3; i++) begin
			bus_write(ADDR_DATA, $random(seed));
			bus_read(ADDR_DATA, value);
			check("count bound", 32'd1, 32'(value <= DEPTH));
		end
		wait_drained(20000);

		// slow fill so the count crosses half once on the way down.
		base = irq_count;
		bus_write(ADDR_DIVISOR, 32'd40);
		for (int i = 0; i < 12; i++)
			bus_write(ADDR_DATA, $random(seed));
		bus_read(ADDR_STATUS, value); // old underruns cleared while the fifo is fed.
		bus_write(ADDR_DIVISOR, 32'd3);
		wait_drained(20000);
		check("interrupt pulses", 32'd1, 32'(irq_count - base));

		wait_silent(silent_frames + 2, 2000);
		bus_write(ADDR_DATA, $random(seed)); // refill, no new underrun.
		bus_write(ADDR_DATA, $random(seed));
		bus_read(ADDR_STATUS, value);
		check("underrun flag", 32'd1, value);
		bus_read(ADDR_STATUS, value);
		check("underrun cleared", 32'd0, value);
		wait_drained(2000);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== sim.f ====
audio_pkg.sv
sample_fifo.sv
audio_regs.sv
rate_timer.sv
sample_serializer.sv
audio_top.sv
audio_properties.sv
tb_audio.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_audio
FILELIST  = sim.f
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
